//--- source/xpu_timing_pkg.sv
// fixed 5 GHz OFDM timing, no band switching and no runtime override
// all times in microseconds unless the name says otherwise
`default_nettype none

package xpu_timing_pkg;

    // 100 MHz system clock
    localparam int CLK_PER_US     = 100;
    localparam int TSF_WIDTH      = 64;
    localparam int US_CNT_WIDTH   = 16;

    localparam int SLOT_TIME_US   = 9;
    localparam int SIFS_TIME_US   = 16;
    localparam int DIFS_TIME_US   = SIFS_TIME_US + 2 * SLOT_TIME_US;

    // contention window is 2^exp - 1 slots
    localparam int CW_EXP_WIDTH   = 4;
    localparam int CW_MIN_EXP     = 4;
    localparam int CW_MAX_EXP     = 10;
    localparam int SLOT_CNT_WIDTH = 10;

    typedef enum logic [1:0] {IDLE, WAIT_DIFS, BACKOFF, GRANT} backoff_state_t;

endpackage

`default_nettype wire

//--- source/wifi_frame_pkg.sv
// 802.11 MAC header layout, only the fields up to address 1
// byte indices count from the first frame control byte
`default_nettype none

package wifi_frame_pkg;

    localparam int FC_WIDTH         = 16;
    localparam int DUR_WIDTH        = 16;
    localparam int MAC_ADDR_WIDTH   = 48;
    localparam int BYTE_IDX_WIDTH   = 16;

    localparam int FC_FIRST_BYTE    = 0;
    localparam int DUR_FIRST_BYTE   = 2;
    localparam int ADDR1_FIRST_BYTE = 4;
    localparam int ADDR1_LAST_BYTE  = 9;

    // bit 15 set means AID or reserved, not a duration
    localparam int NAV_DUR_LIMIT    = 32768;

    // frame control bits 3:2
    typedef enum logic [1:0] {MGMT = 2'b00, CTRL = 2'b01, DATA = 2'b10, RSVD = 2'b11}
        frame_type_t;

endpackage

`default_nettype wire

//--- source/rx_hdr_if.sv
// parsed header fields, valids are single-cycle pulses
// fields hold until the next packet start
`default_nettype none

interface rx_hdr_if import wifi_frame_pkg::*; ();

    logic [FC_WIDTH-1:0]       fc;
    logic [DUR_WIDTH-1:0]      duration;
    logic [MAC_ADDR_WIDTH-1:0] addr1;
    logic                      fc_valid;
    logic                      addr1_valid;

    modport parser (output fc, duration, addr1, fc_valid, addr1_valid);
    modport nav    (input duration, addr1, fc_valid, addr1_valid);

endinterface

`default_nettype wire

//--- source/tsf_timer.sv
// 1 us pulse from a free prescaler, TSF steps on that pulse
// a load restarts the prescaler so the next pulse is a full us later
`default_nettype none

module tsf_timer import xpu_timing_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 tsf_load_i,
    input  logic [TSF_WIDTH-1:0] tsf_load_val_i,
    output logic [TSF_WIDTH-1:0] tsf_o,
    output logic                 tsf_pulse_1m_o
);

    logic [$clog2(CLK_PER_US)-1:0] presc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            presc_q        <= '0;
            tsf_o          <= '0;
            tsf_pulse_1m_o <= 1'b0;
        end else if (tsf_load_i) begin
            presc_q        <= '0;
            tsf_o          <= tsf_load_val_i;
            tsf_pulse_1m_o <= 1'b0;
        end else if (int'(presc_q) == CLK_PER_US - 1) begin
            // pulse and count step land in the same cycle
            presc_q        <= '0;
            tsf_o          <= tsf_o + 1'b1;
            tsf_pulse_1m_o <= 1'b1;
        end else begin
            presc_q        <= presc_q + 1'b1;
            tsf_pulse_1m_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/rx_header_parse.sv
// bytes are taken by index, fields little-endian, no stall on the byte stream
// a byte arriving together with pkt_start_i is dropped
`default_nettype none

module rx_header_parse import wifi_frame_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      pkt_start_i,
    input  logic [7:0]                rx_byte_i,
    input  logic                      rx_byte_valid_i,
    input  logic [BYTE_IDX_WIDTH-1:0] rx_byte_idx_i,
    rx_hdr_if.parser                  hdr
);

    logic [BYTE_IDX_WIDTH-1:0] addr1_off;
    logic                      in_addr1;

    // byte position inside address 1
    assign addr1_off = rx_byte_idx_i - BYTE_IDX_WIDTH'(ADDR1_FIRST_BYTE);
    assign in_addr1  = (rx_byte_idx_i >= ADDR1_FIRST_BYTE) &&
                       (rx_byte_idx_i <= ADDR1_LAST_BYTE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || pkt_start_i) begin
            hdr.fc          <= '0;
            hdr.duration    <= '0;
            hdr.addr1       <= '0;
            hdr.fc_valid    <= 1'b0;
            hdr.addr1_valid <= 1'b0;
        end else begin
            hdr.fc_valid    <= 1'b0;
            hdr.addr1_valid <= 1'b0;
            if (rx_byte_valid_i) begin
                if (rx_byte_idx_i == FC_FIRST_BYTE) begin
                    hdr.fc[7:0] <= rx_byte_i;
                end else if (rx_byte_idx_i == FC_FIRST_BYTE + 1) begin
                    hdr.fc[15:8] <= rx_byte_i;
                    hdr.fc_valid <= 1'b1;
                end else if (rx_byte_idx_i == DUR_FIRST_BYTE) begin
                    hdr.duration[7:0] <= rx_byte_i;
                end else if (rx_byte_idx_i == DUR_FIRST_BYTE + 1) begin
                    hdr.duration[15:8] <= rx_byte_i;
                end else if (in_addr1) begin
                    hdr.addr1[addr1_off*8 +: 8] <= rx_byte_i;
                    // last byte lands with the pulse, so addr1 is whole
                    if (rx_byte_idx_i == ADDR1_LAST_BYTE) begin
                        hdr.addr1_valid <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/nav_tracker.sv
// virtual carrier sense, NAV kept in us and never shortened by a new frame
// durations with bit 15 set are ignored
`default_nettype none

module nav_tracker import xpu_timing_pkg::*, wifi_frame_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    rx_hdr_if.nav                     hdr,
    input  logic [MAC_ADDR_WIDTH-1:0] self_mac_i,
    input  logic                      tsf_pulse_1m_i,
    output logic                      nav_busy_o
);

    logic [US_CNT_WIDTH-1:0] nav_q;
    logic [US_CNT_WIDTH-1:0] nav_dec;
    logic                    hdr_seen_q;
    logic                    nav_hit;

    assign nav_dec = (tsf_pulse_1m_i && nav_q != '0) ? nav_q - 1'b1 : nav_q;

    // only frames whose header started in this packet and are not for us
    assign nav_hit = hdr.addr1_valid && hdr_seen_q &&
                     (hdr.addr1 != self_mac_i) &&
                     (hdr.duration < NAV_DUR_LIMIT);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            nav_q      <= '0;
            hdr_seen_q <= 1'b0;
        end else begin
            if (hdr.fc_valid) begin
                hdr_seen_q <= 1'b1;
            end else if (hdr.addr1_valid) begin
                hdr_seen_q <= 1'b0;
            end
            // keep the longer of the remaining and the new reservation
            if (nav_hit && hdr.duration > nav_dec) begin
                nav_q <= hdr.duration;
            end else begin
                nav_q <= nav_dec;
            end
        end
    end

    assign nav_busy_o = (nav_q != '0);

endmodule

`default_nettype wire

//--- source/cw_exp.sv
// binary exponential backoff window, one step per completed try
`default_nettype none

module cw_exp import xpu_timing_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    tx_done_i,
    input  logic                    tx_ok_i,
    output logic [CW_EXP_WIDTH-1:0] cw_exp_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cw_exp_o <= CW_EXP_WIDTH'(CW_MIN_EXP);
        end else if (tx_done_i) begin
            if (tx_ok_i) begin
                cw_exp_o <= CW_EXP_WIDTH'(CW_MIN_EXP);
            end else if (cw_exp_o < CW_MAX_EXP) begin
                // failed try doubles the window
                cw_exp_o <= cw_exp_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/csma_backoff.sv
// DCF access, DIFS then random slots, frozen count survives a busy channel
// tx_req_i must stay high until the grant, grant holds until tx_done_i
`default_nettype none

module csma_backoff import xpu_timing_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      tsf_pulse_1m_i,
    input  logic                      cca_busy_i,
    input  logic                      nav_busy_i,
    input  logic [CW_EXP_WIDTH-1:0]   cw_exp_i,
    input  logic                      tx_req_i,
    input  logic                      tx_done_i,
    output logic                      tx_grant_o,
    output logic [SLOT_CNT_WIDTH-1:0] num_slot_random_o
);

    backoff_state_t            state_q;
    logic [US_CNT_WIDTH-1:0]   us_cnt_q;
    logic [SLOT_CNT_WIDTH-1:0] slot_left_q;
    logic [SLOT_CNT_WIDTH-1:0] cw_mask;
    logic [SLOT_CNT_WIDTH-1:0] slot_draw;
    logic [15:0]               lfsr_q;
    logic                      busy;

    // physical or virtual carrier sense
    assign busy = cca_busy_i | nav_busy_i;

    assign cw_mask   = {SLOT_CNT_WIDTH{1'b1}} >> (SLOT_CNT_WIDTH - cw_exp_i);
    assign slot_draw = lfsr_q[SLOT_CNT_WIDTH-1:0] & cw_mask;

    // x^16 + x^14 + x^13 + x^11, free running
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lfsr_q <= 16'hace1;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q           <= IDLE;
            us_cnt_q          <= '0;
            slot_left_q       <= '0;
            num_slot_random_o <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (tx_req_i) begin
                        state_q  <= WAIT_DIFS;
                        us_cnt_q <= '0;
                    end
                end
                WAIT_DIFS: begin
                    // first pulse only aligns to the us grid
                    if (busy) begin
                        us_cnt_q <= '0;
                    end else if (tsf_pulse_1m_i) begin
                        if (us_cnt_q == US_CNT_WIDTH'(DIFS_TIME_US)) begin
                            state_q  <= BACKOFF;
                            us_cnt_q <= '0;
                            // frozen count from an earlier attempt is kept
                            if (slot_left_q == '0) begin
                                slot_left_q       <= slot_draw;
                                num_slot_random_o <= slot_draw;
                            end
                        end else begin
                            us_cnt_q <= us_cnt_q + 1'b1;
                        end
                    end
                end
                BACKOFF: begin
                    if (busy) begin
                        state_q  <= WAIT_DIFS;
                        us_cnt_q <= '0;
                    end else if (slot_left_q == '0) begin
                        state_q <= GRANT;
                    end else if (tsf_pulse_1m_i) begin
                        if (us_cnt_q == US_CNT_WIDTH'(SLOT_TIME_US - 1)) begin
                            us_cnt_q    <= '0;
                            slot_left_q <= slot_left_q - 1'b1;
                        end else begin
                            us_cnt_q <= us_cnt_q + 1'b1;
                        end
                    end
                end
                GRANT: begin
                    if (tx_done_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign tx_grant_o = (state_q == GRANT);

endmodule

`default_nettype wire

//--- source/xpu_lite.sv
// MAC timing core, channel busy comes in ready made on cca_busy_i
// single clock domain, 100 MHz assumed by the us prescaler
`default_nettype none

module xpu_lite import xpu_timing_pkg::*, wifi_frame_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [7:0]                rx_byte_i,
    input  logic                      rx_byte_valid_i,
    input  logic [BYTE_IDX_WIDTH-1:0] rx_byte_idx_i,
    input  logic                      pkt_start_i,
    input  logic [MAC_ADDR_WIDTH-1:0] self_mac_i,
    input  logic                      cca_busy_i,
    input  logic                      tx_req_i,
    input  logic                      tx_done_i,
    input  logic                      tx_ok_i,
    input  logic                      tsf_load_i,
    input  logic [TSF_WIDTH-1:0]      tsf_load_val_i,
    output logic [TSF_WIDTH-1:0]      tsf_o,
    output logic                      tsf_pulse_1m_o,
    output logic [FC_WIDTH-1:0]       fc_o,
    output logic [DUR_WIDTH-1:0]      duration_o,
    output logic [MAC_ADDR_WIDTH-1:0] addr1_o,
    output logic                      addr1_valid_o,
    output logic                      nav_busy_o,
    output logic                      tx_grant_o,
    output logic [SLOT_CNT_WIDTH-1:0] num_slot_random_o,
    output logic [CW_EXP_WIDTH-1:0]   cw_exp_o
);

    rx_hdr_if hdr ();

    assign fc_o          = hdr.fc;
    assign duration_o    = hdr.duration;
    assign addr1_o       = hdr.addr1;
    assign addr1_valid_o = hdr.addr1_valid;

    tsf_timer tsf_timer_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .tsf_load_i     (tsf_load_i),
        .tsf_load_val_i (tsf_load_val_i),
        .tsf_o          (tsf_o),
        .tsf_pulse_1m_o (tsf_pulse_1m_o)
    );

    rx_header_parse rx_header_parse_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .pkt_start_i     (pkt_start_i),
        .rx_byte_i       (rx_byte_i),
        .rx_byte_valid_i (rx_byte_valid_i),
        .rx_byte_idx_i   (rx_byte_idx_i),
        .hdr             (hdr.parser)
    );

    nav_tracker nav_tracker_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .hdr            (hdr.nav),
        .self_mac_i     (self_mac_i),
        .tsf_pulse_1m_i (tsf_pulse_1m_o),
        .nav_busy_o     (nav_busy_o)
    );

    cw_exp cw_exp_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .tx_done_i (tx_done_i),
        .tx_ok_i   (tx_ok_i),
        .cw_exp_o  (cw_exp_o)
    );

    csma_backoff csma_backoff_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .tsf_pulse_1m_i    (tsf_pulse_1m_o),
        .cca_busy_i        (cca_busy_i),
        .nav_busy_i        (nav_busy_o),
        .cw_exp_i          (cw_exp_o),
        .tx_req_i          (tx_req_i),
        .tx_done_i         (tx_done_i),
        .tx_grant_o        (tx_grant_o),
        .num_slot_random_o (num_slot_random_o)
    );

endmodule

`default_nettype wire

//--- test/tb_xpu_lite_tasks.svh
// shared helpers, included inside the tb_xpu_lite module body
// inputs are driven and outputs sampled 1 ns after the rising edge
`ifndef TB_XPU_LITE_TASKS_SVH
`define TB_XPU_LITE_TASKS_SVH

// one clock, registered outputs settled and inputs free to change
task automatic tick();
    @(posedge clk_i);
    #1;
endtask

task automatic wait_pulse();
    tick();
    while (!tsf_pulse_1m_o) begin
        tick();
    end
endtask

// 32 bit Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
function automatic logic [63:0] rand_bits(input int nbits);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val        = {val[62:0], fb};
    end
    return val;
endfunction

task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
        $display("ERR %s expected %0h actual %0h", name, exp, act);
        err_cnt++;
    end
endtask

task automatic expect_range(input string name, input longint lo, input longint hi,
                            input longint act);
    assert (act >= lo && act <= hi) else begin
        $display("ERR %s expected %0d..%0d actual %0d", name, lo, hi, act);
        err_cnt++;
    end
endtask

task automatic expect_no_grant(input string cause);
    assert (!tx_grant_o) else begin
        $display("tx grant went high while %s kept the channel busy", cause);
        err_cnt++;
    end
endtask

task automatic expect_nav_idle(input string name);
    logic seen;
    seen = 1'b0;
    repeat (3 * CLK_PER_US) begin
        tick();
        seen = seen | nav_busy_o;
    end
    expect_eq(name, 0, seen);
endtask

// header bytes 0 to 9, little-endian within each field
task automatic send_frame(input logic [15:0] fc, input logic [15:0] dur,
                          input logic [47:0] addr);
    logic [79:0] hdr_bytes;
    hdr_bytes   = {addr, dur, fc};
    pkt_start_i = 1'b1;
    tick();
    pkt_start_i = 1'b0;
    for (int i = 0; i <= ADDR1_LAST_BYTE; i++) begin
        rx_byte_valid_i = 1'b1;
        rx_byte_idx_i   = BYTE_IDX_WIDTH'(i);
        rx_byte_i       = hdr_bytes[i*8 +: 8];
        tick();
    end
    rx_byte_valid_i = 1'b0;
    // byte 9 was taken on the last edge
    expect_eq("addr1_valid after byte 9", 1, addr1_valid_o);
endtask

task automatic pulse_tx_done(input logic ok);
    tx_done_i = 1'b1;
    tx_ok_i   = ok;
    tick();
    tx_done_i = 1'b0;
    tx_ok_i   = 1'b0;
endtask

task automatic wait_grant(input int max_cycles);
    int n;
    n = 0;
    while (!tx_grant_o && n < max_cycles) begin
        tick();
        n++;
    end
    assert (tx_grant_o) else begin
        $display("no tx grant after waiting %0d cycles", max_cycles);
        err_cnt++;
    end
endtask

task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
        $display("test %-8s passed", name);
    end else begin
        fail_cnt++;
        $display("test %-8s failed with %0d errors", name, err_cnt - errs_before);
    end
endtask

`endif

//--- test/tb_xpu_lite.sv
// top level checks for xpu_lite with the 100 MHz clock that the us prescaler assumes
// backoff is only run at cw exponents 4 and 5
`default_nettype none

module tb_xpu_lite import xpu_timing_pkg::*, wifi_frame_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // worst case lengths in us for backoff at cw 5 and NAV frames of up to 531 us
    localparam int BACKOFF_MAX_US = DIFS_TIME_US + 2 + SLOT_TIME_US * 31;
    localparam int RUN_MAX_US     = 10 + 2 * 560 + 3 * BACKOFF_MAX_US + 200;
    localparam int TIMEOUT_CYCLES = RUN_MAX_US * CLK_PER_US + 50_000;

    logic                      clk_i;
    logic                      rst_n_i;
    logic [7:0]                rx_byte_i;
    logic                      rx_byte_valid_i;
    logic [BYTE_IDX_WIDTH-1:0] rx_byte_idx_i;
    logic                      pkt_start_i;
    logic [MAC_ADDR_WIDTH-1:0] self_mac_i;
    logic                      cca_busy_i;
    logic                      tx_req_i;
    logic                      tx_done_i;
    logic                      tx_ok_i;
    logic                      tsf_load_i;
    logic [TSF_WIDTH-1:0]      tsf_load_val_i;
    logic [TSF_WIDTH-1:0]      tsf_o;
    logic                      tsf_pulse_1m_o;
    logic [FC_WIDTH-1:0]       fc_o;
    logic [DUR_WIDTH-1:0]      duration_o;
    logic [MAC_ADDR_WIDTH-1:0] addr1_o;
    logic                      addr1_valid_o;
    logic                      nav_busy_o;
    logic                      tx_grant_o;
    logic [SLOT_CNT_WIDTH-1:0] num_slot_random_o;
    logic [CW_EXP_WIDTH-1:0]   cw_exp_o;

    logic [31:0] lfsr_state   = 32'hdb4159cb;
    longint      cycle_cnt    = 0;
    int          valid_pulses = 0;
    int          err_cnt      = 0;
    int          test_cnt     = 0;
    int          fail_cnt     = 0;

    `include "tb_xpu_lite_tasks.svh"

    xpu_lite UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (addr1_valid_o) begin
            valid_pulses <= valid_pulses + 1;
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without reaching the end", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    // grant may only rise after a cycle of idle channel
    grant_after_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(tx_grant_o) |-> $past(!cca_busy_i && !nav_busy_o))
    else begin
        $display("tx grant rose right after a busy channel cycle");
        err_cnt++;
    end

    task automatic tsf_counting();
        int          e0;
        longint      t0;
        logic [63:0] tsf0;
        logic [63:0] load_val;
        e0 = err_cnt;
        wait_pulse();
        for (int k = 0; k < 3; k++) begin
            t0   = cycle_cnt;
            tsf0 = tsf_o;
            wait_pulse();
            expect_eq("tsf pulse period", CLK_PER_US, cycle_cnt - t0);
            expect_eq("tsf step", tsf0 + 1, tsf_o);
        end
        load_val       = rand_bits(64);
        tsf_load_val_i = load_val;
        tsf_load_i     = 1'b1;
        tick();
        tsf_load_i = 1'b0;
        expect_eq("tsf load", load_val, tsf_o);
        wait_pulse();
        expect_eq("tsf after load", load_val + 1, tsf_o);
        end_test("tsf", e0);
    endtask

    task automatic header_fields();
        int          e0;
        int          p0;
        logic [15:0] fc;
        logic [15:0] dur;
        logic [47:0] addr;
        e0   = err_cnt;
        fc   = 16'(rand_bits(16));
        // bit 15 set so this frame leaves the NAV alone
        dur  = {1'b1, 15'(rand_bits(15))};
        addr = 48'(rand_bits(48));
        p0   = valid_pulses;
        send_frame(fc, dur, addr);
        repeat (4) tick();
        expect_eq("fc", fc, fc_o);
        expect_eq("duration", dur, duration_o);
        expect_eq("addr1", addr, addr1_o);
        expect_eq("addr1_valid pulses", 1, valid_pulses - p0);
        end_test("parser", e0);
    endtask

    task automatic nav_reservation();
        int          e0;
        longint      t0;
        logic [15:0] dur;
        logic [47:0] addr;
        e0   = err_cnt;
        dur  = 16'(20 + rand_bits(9));
        addr = 48'(rand_bits(48));
        if (addr == self_mac_i) begin
            addr = ~addr;
        end
        // fc 0x0008 is a data frame
        send_frame(16'h0008, dur, addr);
        tick();
        expect_eq("nav set", 1, nav_busy_o);
        t0 = cycle_cnt;
        while (nav_busy_o) begin
            tick();
        end
        expect_range("nav length", (dur - 1) * CLK_PER_US, (dur + 1) * CLK_PER_US,
                     cycle_cnt - t0);
        send_frame(16'h0008, dur, self_mac_i);
        expect_nav_idle("nav for own address");
        send_frame(16'h0008, dur | 16'h8000, addr);
        expect_nav_idle("nav for duration above limit");
        end_test("nav", e0);
    endtask

    task automatic window_steps();
        int e0;
        int exp_cw;
        e0 = err_cnt;
        expect_eq("cw after reset", CW_MIN_EXP, cw_exp_o);
        for (int k = 1; k <= 8; k++) begin
            pulse_tx_done(1'b0);
            exp_cw = (CW_MIN_EXP + k > CW_MAX_EXP) ? CW_MAX_EXP : CW_MIN_EXP + k;
            expect_eq("cw after failure", exp_cw, cw_exp_o);
        end
        pulse_tx_done(1'b1);
        expect_eq("cw after success", CW_MIN_EXP, cw_exp_o);
        end_test("window", e0);
    endtask

    task automatic backoff_delay();
        int     e0;
        int     cw;
        int     slots;
        longint t0;
        longint lo;
        e0 = err_cnt;
        // a failed try in between so the second run uses cw 5
        for (int k = 0; k < 2; k++) begin
            cw       = cw_exp_o;
            tx_req_i = 1'b1;
            t0       = cycle_cnt;
            wait_grant(BACKOFF_MAX_US * CLK_PER_US);
            tx_req_i = 1'b0;
            slots    = num_slot_random_o;
            lo       = (DIFS_TIME_US + slots * SLOT_TIME_US) * CLK_PER_US;
            expect_range("slot count", 0, (1 << cw) - 1, slots);
            expect_range("grant delay", lo, lo + 2 * CLK_PER_US, cycle_cnt - t0);
            pulse_tx_done(k == 1);
            expect_eq("grant release", 0, tx_grant_o);
        end
        end_test("backoff", e0);
    endtask

    task automatic busy_freeze();
        int          e0;
        logic [47:0] addr;
        e0       = err_cnt;
        tx_req_i = 1'b1;
        repeat (20 * CLK_PER_US) tick();
        // physical busy in the middle of DIFS
        cca_busy_i = 1'b1;
        repeat (50 * CLK_PER_US) begin
            tick();
            expect_no_grant("cca");
        end
        cca_busy_i = 1'b0;
        addr = ~self_mac_i;
        send_frame(16'h0008, 16'd60, addr);
        tick();
        expect_eq("nav before grant", 1, nav_busy_o);
        while (nav_busy_o) begin
            tick();
            expect_no_grant("nav");
        end
        wait_grant(BACKOFF_MAX_US * CLK_PER_US);
        tx_req_i = 1'b0;
        pulse_tx_done(1'b1);
        end_test("freeze", e0);
    endtask

    initial begin
        rst_n_i         = 1'b0;
        rx_byte_i       = '0;
        rx_byte_valid_i = 1'b0;
        rx_byte_idx_i   = '0;
        pkt_start_i     = 1'b0;
        cca_busy_i      = 1'b0;
        tx_req_i        = 1'b0;
        tx_done_i       = 1'b0;
        tx_ok_i         = 1'b0;
        tsf_load_i      = 1'b0;
        tsf_load_val_i  = '0;
        self_mac_i      = 48'(rand_bits(48));
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        tsf_counting();
        header_fields();
        nav_reservation();
        window_steps();
        backoff_delay();
        busy_freeze();

        $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
source/xpu_timing_pkg.sv
source/wifi_frame_pkg.sv
source/rx_hdr_if.sv
source/tsf_timer.sv
source/rx_header_parse.sv
source/nav_tracker.sv
source/cw_exp.sv
source/csma_backoff.sv
source/xpu_lite.sv
test/tb_xpu_lite.sv

//--- Bender.yml
package:
  name: xpu_lite

sources:
  - source/xpu_timing_pkg.sv
  - source/wifi_frame_pkg.sv
  - source/rx_hdr_if.sv
  - source/tsf_timer.sv
  - source/rx_header_parse.sv
  - source/nav_tracker.sv
  - source/cw_exp.sv
  - source/csma_backoff.sv
  - source/xpu_lite.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_xpu_lite.sv
